//--- logic/colmix.sv
/*
  fetches the two palette bytes of the latched index and builds a 15-bit colour
  colour and delayed blanking leave two pixel strobes after the pixel is sampled
*/
`timescale 1ns/1ps
`include "vid_config.svh"

module colmix (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  vid_pkg::pal_index_t    pix_index,
    // palette ram video port
    output logic [`PAL_AW-1:0]     vid_addr,
    input  vid_pkg::pal_byte_t     vid_rdata,
    // video out
    output logic                   lhbl_dly,
    output logic                   lvbl_dly,
    output vid_pkg::color_t        red,
    output vid_pkg::color_t        green,
    output vid_pkg::color_t        blue
);

    logic             pal_half;
    logic             half_q;
    logic [`RGB_W-1:0] col_q;
    logic             hbl_s1;
    logic             vbl_s1;
    logic             hbl_s2;
    logic             vbl_s2;

    // byte 2i is the high byte, 2i+1 the low byte
    assign vid_addr = {pix_index, pal_half};

    // half is 0 right after the strobe, then 1 on the next strobe cycle
    // so the high byte goes out first
    always_ff @(posedge clk) begin
        if (rst) begin
            pal_half <= 1'b0;
            half_q   <= 1'b0;
        end else begin
            if (pxl_cen) begin
                pal_half <= 1'b0;
            end else begin
                pal_half <= ~pal_half;
            end
            // which byte the ram returns next cycle
            half_q <= pal_half;
        end
    end

    // high byte: unused bit, blue, top two bits of green
    // low byte: low three bits of green, red
    // {blue, green, red} lines up with the two bytes minus the unused bit
    always_ff @(posedge clk) begin
        if (!half_q) begin
            col_q[`RGB_W-1:8] <= vid_rdata[6:0];
        end else begin
            col_q[7:0] <= vid_rdata;
        end
    end

    // blanking pipeline, two strobes deep to match the colour
    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_s1   <= 1'b0;
            vbl_s1   <= 1'b0;
            hbl_s2   <= 1'b0;
            vbl_s2   <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
        end else if (pxl_cen) begin
            hbl_s1   <= lhbl;
            vbl_s1   <= lvbl;
            hbl_s2   <= hbl_s1;
            vbl_s2   <= vbl_s1;
            lhbl_dly <= hbl_s2;
            lvbl_dly <= vbl_s2;
        end
    end

    // output stage, black while either blank is active
    always_ff @(posedge clk) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            if (!hbl_s2 || !vbl_s2) begin
                {blue, green, red} <= '0;
            end else begin
                {blue, green, red} <= col_q;
            end
        end
    end

endmodule

//--- logic/layer_prio.sv
/*
  two-layer priority chooser
  the winning pixel is latched as palette index on every pixel strobe
*/
`timescale 1ns/1ps
`include "vid_config.svh"

module layer_prio (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic [`PIX_W-1:0]      gfx1_pxl,
    input  logic [`PIX_W-1:0]      gfx2_pxl,
    output vid_pkg::pal_index_t    pix_index
);

    vid_pkg::layer_t     layer_sel;
    vid_pkg::pal_index_t pix_mux;

    // layer 2 wins when layer 1 is transparent
    // or when layer 2 carries its priority flag
    always_comb begin
        if (gfx1_pxl[3:0] == 4'h0 || gfx2_pxl[4]) begin
            layer_sel = vid_pkg::LAYER2;
        end else begin
            layer_sel = vid_pkg::LAYER1;
        end
    end

    always_comb begin
        case (layer_sel)
            vid_pkg::LAYER2: pix_mux = gfx2_pxl;
            default:         pix_mux = gfx1_pxl;
        endcase
    end

    // index stays put between strobes while colmix reads its two bytes
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_index <= '0;
        end else if (pxl_cen) begin
            pix_index <= pix_mux;
        end
    end

endmodule

//--- logic/pal_apb.sv
/*
  apb slave in front of the palette ram
  writes complete with no wait, reads take one wait state
  every address in the 8-bit range maps to a palette byte
*/
`timescale 1ns/1ps
`include "vid_config.svh"

module pal_apb (
    input  logic                   clk,
    input  logic                   rst,
    // apb bus
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`PAL_AW-1:0]     paddr,
    input  vid_pkg::pal_byte_t     pwdata,
    output vid_pkg::pal_byte_t     prdata,
    output logic                   pready,
    // palette ram cpu port
    output logic [`PAL_AW-1:0]     cpu_addr,
    output vid_pkg::pal_byte_t     cpu_wdata,
    output logic                   cpu_we,
    input  vid_pkg::pal_byte_t     cpu_rdata
);

    vid_pkg::apb_state_t state;
    vid_pkg::apb_state_t state_nxt;
    logic                access;
    logic                wr_go;
    logic                rd_go;

    // access phase of a transfer
    assign access = psel & penable;

    // first access cycle decides the kind of transfer
    assign wr_go = access & pwrite & (state == vid_pkg::IDLE);
    assign rd_go = access & ~pwrite & (state == vid_pkg::IDLE);

    // address and data go straight to the ram
    // the master holds them until pready
    assign cpu_addr  = paddr;
    assign cpu_wdata = pwdata;
    assign cpu_we    = wr_go;

    // write: ready in the first access cycle
    // read: ready once the ram data is back
    assign pready = wr_go | (state == vid_pkg::READ_WAIT);

    // ram output is valid only in the wait cycle
    assign prdata = (state == vid_pkg::READ_WAIT) ? cpu_rdata : '0;

    always_comb begin
        state_nxt = state;
        case (state)
            vid_pkg::IDLE: begin
                // read issued this cycle, data next cycle
                if (rd_go) begin
                    state_nxt = vid_pkg::READ_WAIT;
                end
            end
            vid_pkg::READ_WAIT: begin
                state_nxt = vid_pkg::IDLE;
            end
            default: begin
                state_nxt = vid_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= vid_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

//--- logic/pal_ram.sv
/*
  256 x 8 palette memory
  cpu port reads and writes, video port only reads
  both reads return data one clock after the address
*/
`timescale 1ns/1ps
`include "vid_config.svh"

module pal_ram (
    input  logic                   clk,
    // cpu port
    input  logic [`PAL_AW-1:0]     cpu_addr,
    input  vid_pkg::pal_byte_t     cpu_wdata,
    input  logic                   cpu_we,
    output vid_pkg::pal_byte_t     cpu_rdata,
    // video port
    input  logic [`PAL_AW-1:0]     vid_addr,
    output vid_pkg::pal_byte_t     vid_rdata
);

    vid_pkg::pal_byte_t mem [0:`PAL_DEPTH-1];

    // cpu side
    // read-before-write, so a write cycle returns the old byte
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        cpu_rdata <= mem[cpu_addr];
    end

    // video side, read only
    always_ff @(posedge clk) begin
        vid_rdata <= mem[vid_addr];
    end

endmodule

//--- logic/vid_colmix_top.sv
/*
  colour mixing stage top level
  cpu loads the palette over apb, video side turns layer pixels into rgb
*/
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_colmix_top (
    input  logic                   clk,
    input  logic                   rst,
    // apb
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`PAL_AW-1:0]     paddr,
    input  vid_pkg::pal_byte_t     pwdata,
    output vid_pkg::pal_byte_t     prdata,
    output logic                   pready,
    // pixel side
    input  logic                   pxl_cen,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  logic [`PIX_W-1:0]      gfx1_pxl,
    input  logic [`PIX_W-1:0]      gfx2_pxl,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly,
    output vid_pkg::color_t        red,
    output vid_pkg::color_t        green,
    output vid_pkg::color_t        blue
);

    // cpu port of the palette
    logic [`PAL_AW-1:0]  cpu_addr;
    vid_pkg::pal_byte_t  cpu_wdata;
    logic                cpu_we;
    vid_pkg::pal_byte_t  cpu_rdata;
    // video port of the palette
    logic [`PAL_AW-1:0]  vid_addr;
    vid_pkg::pal_byte_t  vid_rdata;
    // chosen palette index
    vid_pkg::pal_index_t pix_index;

    pal_apb u_apb (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_rdata (cpu_rdata)
    );

    pal_ram u_ram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_rdata (cpu_rdata),
        .vid_addr  (vid_addr),
        .vid_rdata (vid_rdata)
    );

    layer_prio u_prio (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .gfx1_pxl  (gfx1_pxl),
        .gfx2_pxl  (gfx2_pxl),
        .pix_index (pix_index)
    );

    colmix u_colmix (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .pix_index (pix_index),
        .vid_addr  (vid_addr),
        .vid_rdata (vid_rdata),
        .lhbl_dly  (lhbl_dly),
        .lvbl_dly  (lvbl_dly),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

//--- logic/vid_config.svh
/*
  sizes shared by the colour mixing stage
  include wherever a palette, pixel or colour width is needed
*/
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// palette byte address, 256 bytes in total
`define PAL_AW 8

// number of palette bytes
`define PAL_DEPTH (1 << `PAL_AW)

// layer pixel width
// bits 3:0 hold the colour nibble, bit 4 the priority flag
`define PIX_W 7

// bits per colour component
`define COL_W 5

// assembled colour, blue then green then red
`define RGB_W (3 * `COL_W)

`endif

//--- logic/vid_pkg.sv
/*
  types shared by the palette, priority and mixer blocks
  refer to them by scoped name, e.g. vid_pkg::color_t
*/
`include "vid_config.svh"

package vid_pkg;

    // one colour component
    typedef logic [`COL_W-1:0] color_t;

    // palette entry index, one entry spans two bytes
    typedef logic [`PIX_W-1:0] pal_index_t;

    // palette data byte as seen by the cpu and the video port
    typedef logic [7:0] pal_byte_t;

    // apb slave states
    // reads spend one extra cycle in READ_WAIT
    typedef enum logic {
        IDLE,
        READ_WAIT
    } apb_state_t;

    // which graphics layer wins the pixel
    typedef enum logic {
        LAYER1,
        LAYER2
    } layer_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the colour mixing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module colmix_tb -f sim.f -o colmix_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/colmix_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sim.f
+incdir+logic
logic/vid_pkg.sv
logic/pal_ram.sv
logic/pal_apb.sv
logic/layer_prio.sv
logic/colmix.sv
logic/vid_colmix_top.sv
verification/colmix_sva.sv
verification/colmix_tb.sv

//--- verification/colmix_sva.sv
/*
  assertions on the apb handshake and on output blanking
  bound into the colour mixing top level, which sees both sides
*/
`timescale 1ns/1ps

module colmix_sva (
    input  logic            clk,
    input  logic            rst,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic            pready,
    input  logic            lhbl_dly,
    input  logic            lvbl_dly,
    input  vid_pkg::color_t red,
    input  vid_pkg::color_t green,
    input  vid_pkg::color_t blue
);

    // ready only ever answers an access phase
    a_ready_in_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> (psel && penable))
        else $error("pready high outside an apb access phase");

    // first access cycle of a read is always a wait cycle
    a_read_wait: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !pwrite && !$past(penable)) |-> !pready)
        else $error("apb read accepted without its wait state");

    // black whenever either delayed blank is active
    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        (!lhbl_dly || !lvbl_dly) |-> (red == '0 && green == '0 && blue == '0))
        else $error("colour not zero during blanking");

endmodule

bind vid_colmix_top colmix_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pready   (pready),
    .lhbl_dly (lhbl_dly),
    .lvbl_dly (lvbl_dly),
    .red      (red),
    .green    (green),
    .blue     (blue)
);

//--- verification/colmix_tb.sv
/*
  testbench for the colour mixing stage
  loads a random palette over apb, reads it back, then streams a pixel table
  and rewrites one palette entry while pixels are flowing
*/
`timescale 1ns/1ps
`include "vid_config.svh"

module colmix_tb;

    localparam int SEED      = 69219;
    localparam int MAX_ROWS  = 24;
    // rewrite starts when this row is driven
    localparam int REW_ROW   = 12;
    localparam logic [`PIX_W-1:0] REW_IDX = 7'h2A;
    // writes, read-back and the two rewrite bytes
    localparam int APB_XFERS = 2 * `PAL_DEPTH + 2;
    localparam int WATCHDOG  = APB_XFERS * 4 + (MAX_ROWS + 3) * 2 + 100;

    logic                clk;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [`PAL_AW-1:0]  paddr;
    vid_pkg::pal_byte_t  pwdata;
    vid_pkg::pal_byte_t  prdata;
    logic                pready;
    logic                pxl_cen;
    logic                lhbl;
    logic                lvbl;
    logic [`PIX_W-1:0]   gfx1_pxl;
    logic [`PIX_W-1:0]   gfx2_pxl;
    logic                lhbl_dly;
    logic                lvbl_dly;
    vid_pkg::color_t     red;
    vid_pkg::color_t     green;
    vid_pkg::color_t     blue;

    // palette as the testbench expects it
    vid_pkg::pal_byte_t  pal_model [0:`PAL_DEPTH-1];

    // stimulus table, expected colour filled in when a row is driven
    logic [`PIX_W-1:0]   t_gfx1 [0:MAX_ROWS-1];
    logic [`PIX_W-1:0]   t_gfx2 [0:MAX_ROWS-1];
    logic                t_hbl  [0:MAX_ROWS-1];
    logic                t_vbl  [0:MAX_ROWS-1];
    vid_pkg::color_t     e_red   [0:MAX_ROWS-1];
    vid_pkg::color_t     e_green [0:MAX_ROWS-1];
    vid_pkg::color_t     e_blue  [0:MAX_ROWS-1];
    int                  n_rows;
    int                  row_now;

    int err_color;
    int err_byte;
    int err_flag;

    vid_colmix_top uut (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .gfx1_pxl (gfx1_pxl),
        .gfx2_pxl (gfx2_pxl),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    always #4 clk = ~clk;

    // pixel strobe on every other clock
    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    task automatic check_color(input string name, input vid_pkg::color_t exp,
                               input vid_pkg::color_t act);
        if (exp !== act) begin
            err_color++;
            $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input vid_pkg::pal_byte_t exp,
                              input vid_pkg::pal_byte_t act);
        if (exp !== act) begin
            err_byte++;
            $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input bit act);
        if (exp !== act) begin
            err_flag++;
            $display("MISMATCH %s expected %0b actual %0b", name, exp, act);
        end
    endtask

    // setup cycle, then access until pready, sampled on the falling edge
    task automatic apb_write(input logic [`PAL_AW-1:0] addr, input vid_pkg::pal_byte_t data);
        int waits;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (pready !== 1'b1) begin
            waits++;
            @(negedge clk);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pal_model[addr] = data;
        check_flag($sformatf("write %02h zero wait", addr), 1'b1, waits == 0);
    endtask

    task automatic apb_read(input logic [`PAL_AW-1:0] addr,
                            output vid_pkg::pal_byte_t data, output int waits);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (pready !== 1'b1) begin
            waits++;
            @(negedge clk);
        end
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // priority rule and byte format applied to the model palette
    task automatic expect_pixel(input logic [`PIX_W-1:0] g1, input logic [`PIX_W-1:0] g2,
                                input logic hb, input logic vb,
                                output vid_pkg::color_t r, output vid_pkg::color_t g,
                                output vid_pkg::color_t b);
        vid_pkg::layer_t     layer;
        vid_pkg::pal_index_t idx;
        vid_pkg::pal_byte_t  hi;
        vid_pkg::pal_byte_t  lo;
        if (g1[3:0] == 4'h0 || g2[4]) begin
            layer = vid_pkg::LAYER2;
        end else begin
            layer = vid_pkg::LAYER1;
        end
        idx = (layer == vid_pkg::LAYER2) ? g2 : g1;
        hi  = pal_model[{idx, 1'b0}];
        lo  = pal_model[{idx, 1'b1}];
        if (!hb || !vb) begin
            r = '0;
            g = '0;
            b = '0;
        end else begin
            b = hi[6:2];
            g = {hi[1:0], lo[7:5]};
            r = lo[4:0];
        end
    endtask

    task automatic add_row(input logic [`PIX_W-1:0] g1, input logic [`PIX_W-1:0] g2,
                           input logic hb, input logic vb);
        t_gfx1[n_rows] = g1;
        t_gfx2[n_rows] = g2;
        t_hbl[n_rows]  = hb;
        t_vbl[n_rows]  = vb;
        n_rows++;
    endtask

    // returns on a clock edge where the DUT sees pxl_cen high
    task automatic wait_cen();
        do begin
            @(posedge clk);
        end while (pxl_cen !== 1'b1);
    endtask

    // a row driven on one strobe edge is sampled on the next
    // and shows up on the output two strobes after that
    task automatic stream_pixels();
        for (int i = 0; i < n_rows + 3; i++) begin
            wait_cen();
            if (i < n_rows) begin
                gfx1_pxl <= t_gfx1[i];
                gfx2_pxl <= t_gfx2[i];
                lhbl     <= t_hbl[i];
                lvbl     <= t_vbl[i];
                expect_pixel(t_gfx1[i], t_gfx2[i], t_hbl[i], t_vbl[i],
                             e_red[i], e_green[i], e_blue[i]);
            end else begin
                gfx1_pxl <= '0;
                gfx2_pxl <= '0;
                lhbl     <= 1'b0;
                lvbl     <= 1'b0;
            end
            row_now = i;
            @(negedge clk);
            if (i >= 3) begin
                check_color($sformatf("row %0d red", i - 3), e_red[i - 3], red);
                check_color($sformatf("row %0d green", i - 3), e_green[i - 3], green);
                check_color($sformatf("row %0d blue", i - 3), e_blue[i - 3], blue);
                check_flag($sformatf("row %0d lhbl_dly", i - 3), t_hbl[i - 3], lhbl_dly);
                check_flag($sformatf("row %0d lvbl_dly", i - 3), t_vbl[i - 3], lvbl_dly);
            end
        end
    endtask

    // new colour for one entry while the stream runs
    task automatic rewrite_entry();
        wait (row_now >= REW_ROW);
        apb_write({REW_IDX, 1'b0}, ~pal_model[{REW_IDX, 1'b0}]);
        apb_write({REW_IDX, 1'b1}, ~pal_model[{REW_IDX, 1'b1}]);
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        vid_pkg::pal_byte_t rd;
        int                 waits;
        clk      = 1'b0;
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        pxl_cen  = 1'b0;
        lhbl     = 1'b0;
        lvbl     = 1'b0;
        gfx1_pxl = '0;
        gfx2_pxl = '0;
        err_color = 0;
        err_byte  = 0;
        err_flag  = 0;
        n_rows    = 0;
        row_now   = -1;
        void'($urandom(SEED));

        // layer 1 opaque, layer 2 without priority
        add_row(7'h21, 7'h03, 1'b1, 1'b1);
        add_row(7'h4F, 7'h6A, 1'b1, 1'b1);
        add_row(7'h15, 7'h0C, 1'b1, 1'b1);
        // layer 1 transparent or layer 2 priority
        add_row(7'h30, 7'h45, 1'b1, 1'b1);
        add_row(7'h13, 7'h55, 1'b1, 1'b1);
        add_row(7'h7E, 7'h1F, 1'b1, 1'b1);
        add_row(7'h00, 7'h7F, 1'b1, 1'b1);
        // blanking
        add_row(7'h21, 7'h03, 1'b0, 1'b1);
        add_row(7'h33, 7'h44, 1'b1, 1'b0);
        add_row(7'h5C, 7'h12, 1'b0, 1'b0);
        add_row(7'h66, 7'h07, 1'b1, 1'b1);
        add_row(7'h0B, 7'h31, 1'b1, 1'b1);
        // rewrite in flight, entry 2A kept out of these rows
        add_row(7'h19, 7'h02, 1'b1, 1'b1);
        add_row(7'h0E, 7'h60, 1'b1, 1'b1);
        add_row(7'h47, 7'h08, 1'b1, 1'b1);
        add_row(7'h3C, 7'h59, 1'b1, 1'b1);
        add_row(7'h71, 7'h04, 1'b1, 1'b1);
        add_row(7'h0D, 7'h0D, 1'b1, 1'b1);
        // new colour of entry 2A
        add_row(REW_IDX, 7'h00, 1'b1, 1'b1);
        add_row(7'h00, REW_IDX, 1'b1, 1'b1);
        add_row(REW_IDX, 7'h05, 1'b0, 1'b1);
        add_row(REW_IDX, 7'h00, 1'b1, 1'b1);

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int a = 0; a < `PAL_DEPTH; a++) begin
            apb_write(8'(a), 8'($urandom));
        end
        for (int a = 0; a < `PAL_DEPTH; a++) begin
            apb_read(8'(a), rd, waits);
            check_byte($sformatf("read %02h", a), pal_model[a], rd);
            check_flag($sformatf("read %02h one wait", a), 1'b1, waits == 1);
        end

        fork
            stream_pixels();
            rewrite_entry();
        join

        $display("errors: color %0d byte %0d flag %0d", err_color, err_byte, err_flag);
        if (err_color == 0 && err_byte == 0 && err_flag == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
